//--- run.sh
#!/bin/sh
# build and run the TCB memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tcb_mem_tb -Mdir obj_dir -o tcb_mem_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tcb_mem_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^All checks passed$'; then
  exit 0
fi
exit 1

//--- src/tcb_mem_array.sv
/*
 * TCB memory banks
 * four byte wide banks, each with its own row address and
 * write enable, synchronous write and registered read
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_array
  import tcb_mem_pkg::*;
(
  input  wire   tcb,
  input  row_t  row [BYT_N],
  input  logic  wen [BYT_N],
  input  byte_t wdt [BYT_N],
  output dat_t  rdt
);

  // registered read data per bank
  byte_t rd [BYT_N];

  for (genvar k = 0; k < BYT_N; k++) begin: bank

    byte_t mem [MEM_ROWS];

    // read returns the old contents on a same row write
    always_ff @(posedge tcb) begin
      if (wen[k]) begin
        mem[row[k]] <= wdt[k];
      end
      rd[k] <= mem[row[k]];
    end

    // bank k is byte k of the word
    assign rdt[8*k +: 8] = rd[k];

  end: bank

endmodule: tcb_mem_array

`default_nettype wire

//--- src/tcb_mem_cnt.sv
/*
 * TCB memory row counter
 * steps through the bank rows during the clearing sweep
 * and flags the last row
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_cnt
  import tcb_mem_pkg::*;
(
  input  wire  tcb,
  input  wire  arst_n,
  // count enable from the controller
  input  wire  en,
  output row_t cnt,
  output logic last
);

  // one row per enabled cycle, wraps after the last row
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (en) begin
      cnt <= cnt + row_t'(1);
    end
  end

  // top row of the banks
  assign last = (cnt == row_t'(MEM_ROWS - 1));

endmodule: tcb_mem_cnt

`default_nettype wire

//--- src/tcb_mem_ctrl.sv
/*
 * TCB memory controller
 * runs the clearing sweep after reset and then hands
 * the banks to the lane logic, raising ready
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_ctrl (
  input  wire  tcb,
  input  wire  arst_n,
  // sweep counter at its last row
  input  wire  last,
  output logic cnt_en,
  output logic clr,
  output logic rdy
);

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    ST_CLR = 1'b0,  // clearing sweep
    ST_RUN = 1'b1   // normal operation
  } state_t;

  state_t state;
  state_t state_nxt;

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      ST_CLR: begin
        // last row written at this edge
        if (last) begin
          state_nxt = ST_RUN;
        end
      end
      ST_RUN: begin
        state_nxt = ST_RUN;
      end
      default: begin
        state_nxt = ST_CLR;
      end
    endcase
  end

  // reset always restarts the sweep
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_CLR;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  // sweep owns the banks and steps the counter
  assign clr    = (state == ST_CLR);
  assign cnt_en = (state == ST_CLR);
  // port accepts transfers only once running
  assign rdy    = (state == ST_RUN);

endmodule: tcb_mem_ctrl

`default_nettype wire

//--- src/tcb_mem_dly.sv
/*
 * TCB memory response delay line
 * shift register of DLY stages for any packed payload
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_dly #(
  // payload type
  parameter type         T   = logic [8-1:0],
  // stage count, at least 1
  parameter int unsigned DLY = 1
)(
  input  wire tcb,
  input  wire arst_n,
  input  T    d,
  output T    q
);

  T stg [DLY];

  // stage 0 takes the input, the rest shift along
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DLY; i++) begin
        stg[i] <= '0;
      end
    end else begin
      stg[0] <= d;
      for (int i = 1; i < DLY; i++) begin
        stg[i] <= stg[i-1];
      end
    end
  end

  assign q = stg[DLY-1];

endmodule: tcb_mem_dly

`default_nettype wire

//--- src/tcb_mem_lane.sv
/*
 * TCB memory lane logic
 * maps a byte address and log2 size onto per bank rows,
 * rotates write data into the banks and read data back out,
 * flags illegal sizes
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_lane
  import tcb_mem_pkg::*;
(
  // request side
  input  wire   trn,
  input  wire   wen,
  input  adr_t  adr,
  input  siz_t  siz,
  input  dat_t  wdt,
  output row_t  bank_row [BYT_N],
  output logic  bank_wen [BYT_N],
  output byte_t bank_wdt [BYT_N],
  output meta_t meta,
  // response side
  input  meta_t meta_d,
  input  dat_t  bank_rdt,
  output logic  rsp_vld,
  output dat_t  rdt,
  output logic  sts
);

  // byte views of the data words
  byte_t [BYT_N-1:0] wdt_b;
  byte_t [BYT_N-1:0] rdt_b;
  byte_t [BYT_N-1:0] bank_b;

  // request byte b is covered by a transfer of size siz
  function automatic logic lane_cov(input siz_t s, input logic [1:0] b);
    case (s)
      2'd0:    lane_cov = (b == 2'd0);
      2'd1:    lane_cov = ~b[1];
      2'd2:    lane_cov = 1'b1;
      default: lane_cov = 1'b0;
    endcase
  endfunction

  assign wdt_b  = wdt;
  assign bank_b = bank_rdt;

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [1:0] b;
    adr_t       a;
    for (int k = 0; k < BYT_N; k++) begin
      // request byte that lands in bank k
      b = 2'(k) - adr[1:0];
      // its byte address, wraps at the memory end
      a = adr + adr_t'(b);
      bank_row[k] = a[ADR_W-1:2];
      // size 3 covers no lane, so nothing gets written
      bank_wen[k] = trn & wen & lane_cov(siz, b);
      bank_wdt[k] = wdt_b[b];
    end
  end

  // bookkeeping for the response
  always_comb begin
    meta.vld = trn;
    meta.wen = wen;
    meta.err = (siz == 2'd3);
    meta.off = adr[1:0];
    meta.siz = siz;
  end

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [1:0] s;
    for (int b = 0; b < BYT_N; b++) begin
      // bank holding response byte b
      s = 2'(b) + meta_d.off;
      // writes, errors and lanes above the size read zero
      if (!meta_d.vld || meta_d.wen || meta_d.err || !lane_cov(meta_d.siz, 2'(b))) begin
        rdt_b[b] = '0;
      end else begin
        rdt_b[b] = bank_b[s];
      end
    end
  end

  assign rdt     = rdt_b;
  assign rsp_vld = meta_d.vld;
  assign sts     = meta_d.vld & meta_d.err;

endmodule: tcb_mem_lane

`default_nettype wire

//--- src/tcb_mem_pkg.sv
/*
 * TCB memory subordinate, shared definitions
 * sizes, response latency and the types passed between
 * the controller, lane logic, banks and delay lines
 */

`default_nettype none

package tcb_mem_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // memory size in bytes
  localparam int unsigned MEM_SIZ  = 256;
  // bytes per word, also the bank count
  localparam int unsigned BYT_N    = 4;
  localparam int unsigned DAT_W    = 8 * BYT_N;
  localparam int unsigned ADR_W    = $clog2(MEM_SIZ);
  // rows per bank
  localparam int unsigned MEM_ROWS = MEM_SIZ / BYT_N;
  localparam int unsigned ROW_W    = $clog2(MEM_ROWS);

  // cycles from transfer edge to response edge
  localparam int unsigned RSP_DLY  = 2;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [8-1:0]     byte_t;
  typedef logic [DAT_W-1:0] dat_t;
  typedef logic [ADR_W-1:0] adr_t;
  typedef logic [ROW_W-1:0] row_t;
  // log2 of transfer size, 3 is illegal
  typedef logic [2-1:0]     siz_t;

  // per transfer bookkeeping, travels alongside the read data
  typedef struct packed {
    logic         vld;  // response due
    logic         wen;  // write transfer
    logic         err;  // illegal size
    logic [2-1:0] off;  // byte offset within word
    siz_t         siz;
  } meta_t;

endpackage: tcb_mem_pkg

`default_nettype wire

//--- src/tcb_mem_top.sv
/*
 * TCB memory subordinate, 256 bytes behind one port
 * any size at any byte address, fixed response latency,
 * zeroed by a sweep after reset
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_top
  import tcb_mem_pkg::*;
(
  input  wire  tcb,
  input  wire  arst_n,
  // request
  input  wire  vld,
  input  wire  wen,
  input  adr_t adr,
  input  siz_t siz,
  input  dat_t wdt,
  output logic rdy,
  // response
  output logic rsp_vld,
  output dat_t rdt,
  output logic sts
);

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  logic  trn;
  logic  clr;
  logic  cnt_en;
  logic  last;
  row_t  cnt;

  // lane logic bank controls
  row_t  lane_row [BYT_N];
  logic  lane_wen [BYT_N];
  byte_t lane_wdt [BYT_N];
  // controls seen by the banks
  row_t  arr_row [BYT_N];
  logic  arr_wen [BYT_N];
  byte_t arr_wdt [BYT_N];

  dat_t  arr_rdt;
  dat_t  arr_rdt_d;
  meta_t meta;
  meta_t meta_d;

  // transfer on valid and ready
  assign trn = vld & rdy;

  ////////////////////////////////////////////////////////////
  // clearing sweep
  ////////////////////////////////////////////////////////////

  tcb_mem_ctrl u_ctrl (
    .tcb    (tcb),
    .arst_n (arst_n),
    .last   (last),
    .cnt_en (cnt_en),
    .clr    (clr),
    .rdy    (rdy)
  );

  tcb_mem_cnt u_cnt (
    .tcb    (tcb),
    .arst_n (arst_n),
    .en     (cnt_en),
    .cnt    (cnt),
    .last   (last)
  );

  ////////////////////////////////////////////////////////////
  // lanes and banks
  ////////////////////////////////////////////////////////////

  tcb_mem_lane u_lane (
    .trn      (trn),
    .wen      (wen),
    .adr      (adr),
    .siz      (siz),
    .wdt      (wdt),
    .bank_row (lane_row),
    .bank_wen (lane_wen),
    .bank_wdt (lane_wdt),
    .meta     (meta),
    .meta_d   (meta_d),
    .bank_rdt (arr_rdt_d),
    .rsp_vld  (rsp_vld),
    .rdt      (rdt),
    .sts      (sts)
  );

  // sweep writes zero to one row of every bank
  always_comb begin
    for (int k = 0; k < BYT_N; k++) begin
      arr_row[k] = clr ? cnt : lane_row[k];
      arr_wen[k] = clr | lane_wen[k];
      arr_wdt[k] = clr ? '0 : lane_wdt[k];
    end
  end

  tcb_mem_array u_array (
    .tcb (tcb),
    .row (arr_row),
    .wen (arr_wen),
    .wdt (arr_wdt),
    .rdt (arr_rdt)
  );

  ////////////////////////////////////////////////////////////
  // response delay
  ////////////////////////////////////////////////////////////

  // metadata for the full latency
  tcb_mem_dly #(
    .T   (meta_t),
    .DLY (RSP_DLY)
  ) u_dly_meta (
    .tcb    (tcb),
    .arst_n (arst_n),
    .d      (meta),
    .q      (meta_d)
  );

  // bank read already spent one cycle
  tcb_mem_dly #(
    .T   (dat_t),
    .DLY (RSP_DLY - 1)
  ) u_dly_rdt (
    .tcb    (tcb),
    .arst_n (arst_n),
    .d      (arr_rdt),
    .q      (arr_rdt_d)
  );

endmodule: tcb_mem_top

`default_nettype wire

//--- test/tcb_mem_tb.sv
/*
 * TCB memory subordinate testbench
 * directed tests against a byte array reference model,
 * responses checked in order at every rsp_vld
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_tb
  import tcb_mem_pkg::*;
();

  localparam int          CLK_P = 100;
  localparam int          RST_N = 16;
  localparam int          RND_N = 200;
  // transfers over all tests
  localparam int          XFER_N = 4 + 4 + 8 + 6 + 8 + 3 + RND_N;
  // two resets, each followed by a full sweep
  localparam int          WDOG_CYC = 2 * (RST_N + MEM_ROWS) + XFER_N + 100;
  localparam int unsigned SEED = 32'h602f;

  localparam siz_t SZ_B = 2'd0;
  localparam siz_t SZ_H = 2'd1;
  localparam siz_t SZ_W = 2'd2;
  localparam siz_t SZ_X = 2'd3;

  logic tcb = 1'b0;
  logic arst_n;
  logic vld;
  logic wen;
  adr_t adr;
  siz_t siz;
  dat_t wdt;
  logic rdy;
  logic rsp_vld;
  dat_t rdt;
  logic sts;

  int cyc = 0;
  int errors = 0;
  int checks = 0;

  // rdy has come up since the last reset
  logic rdy_on = 1'b0;

  // reference memory and expected responses
  logic [7:0] model [MEM_SIZ];
  int         exp_due [$];
  dat_t       exp_rdt [$];
  logic       exp_sts [$];

  tcb_mem_top dut (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  always #(CLK_P / 2) tcb = ~tcb;

  // edge count, transfer and response times refer to it
  always @(posedge tcb) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // reference model and compare tasks
  ////////////////////////////////////////////////////////////

  // bytes adr to adr+size-1, wrapping at the memory end
  task automatic model_xfer(input logic w, input adr_t a, input siz_t s, input dat_t d,
                            output dat_t r, output logic e);
    int n;
    int idx;
    r = '0;
    e = (s == SZ_X);
    n = e ? 0 : (1 << s);
    for (int i = 0; i < n; i++) begin
      idx = (int'(a) + i) % MEM_SIZ;
      if (w) begin
        model[idx] = d[8*i +: 8];
      end else begin
        r[8*i +: 8] = model[idx];
      end
    end
  endtask

  task automatic check_rdt(input dat_t got, input dat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t rdt got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_sts(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t sts got %b expected %b", $time, got, exp);
    end
  endtask

  // port control flags, rdy and rsp_vld
  task automatic check_ctl(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////

  // falling edge, away from the edges where the DUT updates
  always @(negedge tcb) begin
    dat_t r;
    logic e;
    // once up, rdy holds until the next reset
    if (!arst_n) begin
      rdy_on = 1'b0;
    end else if (rdy_on) begin
      check_ctl("rdy", rdy, 1'b1);
    end else if (rdy === 1'b1) begin
      rdy_on = 1'b1;
    end
    if (rsp_vld) begin
      if (exp_due.size() == 0) begin
        errors++;
        $display("response at cycle %0d with no transfer outstanding", cyc + 1);
      end else begin
        if (exp_due[0] != cyc + 1) begin
          errors++;
          $display("response due at cycle %0d came at cycle %0d", exp_due[0], cyc + 1);
        end
        check_rdt(rdt, exp_rdt[0]);
        check_sts(sts, exp_sts[0]);
        void'(exp_due.pop_front());
        void'(exp_rdt.pop_front());
        void'(exp_sts.pop_front());
      end
    end else if (exp_due.size() > 0 && exp_due[0] <= cyc + 1) begin
      errors++;
      $display("no response for the transfer due at cycle %0d", exp_due[0]);
      void'(exp_due.pop_front());
      void'(exp_rdt.pop_front());
      void'(exp_sts.pop_front());
    end
    // transfer takes place at the next rising edge
    if (vld && rdy && arst_n) begin
      model_xfer(wen, adr, siz, wdt, r, e);
      exp_due.push_back(cyc + 1 + int'(RSP_DLY));
      exp_rdt.push_back(r);
      exp_sts.push_back(e);
    end
  end

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  // called at a rising edge, returns at the transfer edge
  task automatic xfer(input logic w, input adr_t a, input siz_t s, input dat_t d);
    vld <= 1'b1;
    wen <= w;
    adr <= a;
    siz <= s;
    wdt <= d;
    @(negedge tcb);
    while (!rdy) @(negedge tcb);
    @(posedge tcb);
  endtask

  task automatic write_xfer(input adr_t a, input siz_t s, input dat_t d);
    xfer(1'b1, a, s, d);
  endtask

  task automatic read_xfer(input adr_t a, input siz_t s);
    xfer(1'b0, a, s, 32'h0);
  endtask

  // idle the port until every response is in
  task automatic drain();
    int n;
    vld <= 1'b0;
    n = 0;
    while (exp_due.size() > 0 && n < int'(RSP_DLY) + 4) begin
      @(posedge tcb);
      n++;
    end
    if (exp_due.size() > 0) begin
      errors++;
      $display("%0d responses never arrived", exp_due.size());
      exp_due.delete();
      exp_rdt.delete();
      exp_sts.delete();
    end
  endtask

  // hold reset, release it and wait out the sweep
  task automatic reset_dut();
    arst_n <= 1'b0;
    repeat (RST_N) @(posedge tcb);
    arst_n <= 1'b1;
    @(negedge tcb);
    check_ctl("rdy", rdy, 1'b0);
    check_ctl("rsp_vld", rsp_vld, 1'b0);
    while (!rdy) @(negedge tcb);
    @(posedge tcb);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    reset_dut();
    // give the next sweep something to clear
    write_xfer(8'h00, SZ_W, 32'h5a5a_0001);
    write_xfer(8'h44, SZ_W, 32'h5a5a_0002);
    write_xfer(8'h80, SZ_W, 32'h5a5a_0003);
    write_xfer(8'hfc, SZ_W, 32'h5a5a_0004);
    drain();
    reset_dut();
    foreach (model[i]) model[i] = 8'h00;
    read_xfer(8'h00, SZ_W);
    read_xfer(8'h44, SZ_W);
    read_xfer(8'h80, SZ_W);
    read_xfer(8'hfc, SZ_W);
    drain();
  endtask

  task automatic test_aligned();
    write_xfer(8'h10, SZ_W, 32'h0123_4567);
    // read one cycle after the write
    read_xfer(8'h10, SZ_W);
    write_xfer(8'h14, SZ_W, 32'h89ab_cdef);
    write_xfer(8'h18, SZ_W, 32'hdead_beef);
    write_xfer(8'h1c, SZ_W, 32'hcafe_f00d);
    read_xfer(8'h14, SZ_W);
    read_xfer(8'h18, SZ_W);
    read_xfer(8'h1c, SZ_W);
    drain();
  endtask

  task automatic test_narrow();
    write_xfer(8'h40, SZ_W, 32'h1122_3344);
    write_xfer(8'h41, SZ_B, 32'h5566_77aa);
    write_xfer(8'h42, SZ_H, 32'h9988_beef);
    read_xfer(8'h40, SZ_W);
    // upper lanes read zero
    read_xfer(8'h43, SZ_B);
    read_xfer(8'h41, SZ_H);
    drain();
  endtask

  task automatic test_misaligned();
    write_xfer(8'h81, SZ_W, 32'ha1a2_a3a4);
    write_xfer(8'hfe, SZ_W, 32'hb1b2_b3b4);
    // wraps past the memory end, overlaps the one before
    write_xfer(8'hff, SZ_W, 32'hc1c2_c3c4);
    write_xfer(8'h13, SZ_W, 32'hd1d2_d3d4);
    read_xfer(8'h81, SZ_W);
    read_xfer(8'hfe, SZ_W);
    read_xfer(8'hff, SZ_W);
    read_xfer(8'h13, SZ_W);
    drain();
  endtask

  task automatic test_illegal();
    write_xfer(8'h40, SZ_X, 32'hffff_ffff);
    read_xfer(8'h40, SZ_X);
    read_xfer(8'h40, SZ_W);
    drain();
  endtask

  task automatic test_random();
    logic w;
    adr_t a;
    siz_t s;
    dat_t d;
    for (int i = 0; i < RND_N; i++) begin
      w = 1'($urandom_range(1, 0));
      a = adr_t'($urandom_range(MEM_SIZ - 1, 0));
      s = siz_t'($urandom_range(2, 0));
      d = $urandom();
      xfer(w, a, s, d);
    end
    drain();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    arst_n <= 1'b0;
    vld    <= 1'b0;
    wen    <= 1'b0;
    adr    <= '0;
    siz    <= '0;
    wdt    <= '0;
    foreach (model[i]) model[i] = 8'h00;
    test_reset();
    test_aligned();
    test_narrow();
    test_misaligned();
    test_illegal();
    test_random();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WDOG_CYC * CLK_P);
    $display("timeout after %0d cycles", WDOG_CYC);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/tcb_mem_pkg.sv
src/tcb_mem_cnt.sv
src/tcb_mem_ctrl.sv
src/tcb_mem_lane.sv
src/tcb_mem_array.sv
src/tcb_mem_dly.sv
src/tcb_mem_top.sv
test/tcb_mem_tb.sv
